// ==== vlog.f ====
cache_geom_pkg.sv
dir_xact_pkg.sv
set_state_ram.sv
state_arbiter.sv
plru_tree.sv
lookup_engine.sv
fill_engine.sv
tag_dir_top.sv
tag_dir_properties.sv
tb_tag_dir.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_tag_dir
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := >>> FAIL
PASS_MSG := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -- "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q -- "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_tag_dir.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tag_dir
	import cache_geom_pkg::*;
	import dir_xact_pkg::*;
();

	localparam int num_sets = 16;
	localparam int timeout_cycles = 40;

	typedef enum logic [1:0] {
		op_lookup,
		op_fill,
		op_both
	} op_t;

	typedef struct packed {
		op_t op;
		line_addr_t lookup_addr;
		line_addr_t fill_addr;
		logic exp_hit;
		way_idx_t exp_way; // shared by both ports on op_both rows
		logic exp_present;
	} row_t;

	logic clk;
	logic reset;
	lookup_req_t lookup_req;
	lookup_rsp_t lookup_rsp;
	fill_req_t fill_req;
	fill_rsp_t fill_rsp;
	row_t rows [$];

	tag_dir_top #(.num_sets(num_sets)) dut_i (
		.clk(clk),
		.reset(reset),
		.lookup_req(lookup_req),
		.lookup_rsp(lookup_rsp),
		.fill_req(fill_req),
		.fill_rsp(fill_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_lookup(input int row, input lookup_rsp_t got, input lookup_rsp_t exp);
		if (got.hit !== exp.hit || (exp.hit && got.way !== exp.way)) begin
			$display("ERR row %0d lookup_rsp got %h exp %h", row, got, exp);
			abort_run();
		end
	endtask

	task automatic check_fill(input int row, input fill_rsp_t got, input fill_rsp_t exp);
		if (got.way !== exp.way || got.was_present !== exp.was_present) begin
			$display("ERR row %0d fill_rsp got %h exp %h", row, got, exp);
			abort_run();
		end
	endtask

	task automatic add_row(input op_t op, input line_addr_t la, input line_addr_t fa,
			input logic hit, input way_idx_t way, input logic present);
		row_t r;
		r.op = op;
		r.lookup_addr = la;
		r.fill_addr = fa;
		r.exp_hit = hit;
		r.exp_way = way;
		r.exp_present = present;
		rows.push_back(r);
	endtask

	//////////////////////////////
	// stimulus table
	//////////////////////////////

	task automatic build_table();
		add_row(op_lookup, 16'h0003, 16'h0000, 1'b0, 3'd0, 1'b0); // empty after reset
		add_row(op_lookup, 16'h1234, 16'h0000, 1'b0, 3'd0, 1'b0);
		add_row(op_lookup, 16'hffff, 16'h0000, 1'b0, 3'd0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			add_row(op_fill, 16'h0000, 16'h0003 + 16'(i * 16), 1'b0, way_idx_t'(i), 1'b0);
		end
		for (int i = 0; i < 8; i++) begin
			add_row(op_lookup, 16'h0003 + 16'(i * 16), 16'h0000, 1'b1, way_idx_t'(i), 1'b0);
		end
		// touches 0..7 leave every node at 0, victim way 0
		add_row(op_fill, 16'h0000, 16'h0023, 1'b0, 3'd2, 1'b1); // already there
		add_row(op_lookup, 16'h0023, 16'h0000, 1'b1, 3'd2, 1'b0);
		// root 1, node 2 = 0, node 5 = 0 -> way 4
		add_row(op_fill, 16'h0000, 16'h0083, 1'b0, 3'd4, 1'b0);
		add_row(op_lookup, 16'h0043, 16'h0000, 1'b0, 3'd0, 1'b0); // evicted
		add_row(op_lookup, 16'h0083, 16'h0000, 1'b1, 3'd4, 1'b0);
		// victim is way 0 now, touching it moves the victim to way 6
		add_row(op_lookup, 16'h0003, 16'h0000, 1'b1, 3'd0, 1'b0);
		add_row(op_fill, 16'h0000, 16'h0093, 1'b0, 3'd6, 1'b0);
		add_row(op_lookup, 16'h0063, 16'h0000, 1'b0, 3'd0, 1'b0);
		add_row(op_lookup, 16'h0093, 16'h0000, 1'b1, 3'd6, 1'b0);
		add_row(op_both, 16'h0013, 16'h0013, 1'b1, 3'd1, 1'b1); // order independent
		add_row(op_both, 16'h0073, 16'h0073, 1'b1, 3'd7, 1'b1);
		add_row(op_lookup, 16'h0033, 16'h0000, 1'b1, 3'd3, 1'b0);
	endtask

	task automatic run_row(input int idx, input row_t r);
		lookup_rsp_t got_l;
		fill_rsp_t got_f;
		lookup_rsp_t exp_l;
		fill_rsp_t exp_f;
		logic want_l;
		logic want_f;
		logic seen_l;
		logic seen_f;
		int cycles;
		want_l = (r.op != op_fill);
		want_f = (r.op != op_lookup);
		seen_l = 1'b0;
		seen_f = 1'b0;
		got_l = '0;
		got_f = '0;
		cycles = 0;
		@(posedge clk);
		#1;
		lookup_req.valid = want_l;
		lookup_req.addr = r.lookup_addr;
		fill_req.valid = want_f;
		fill_req.addr = r.fill_addr;
		@(posedge clk);
		#1;
		lookup_req.valid = 1'b0; // one-cycle strobe
		fill_req.valid = 1'b0;
		while ((want_l && !seen_l) || (want_f && !seen_f)) begin
			if (cycles >= timeout_cycles) begin
				$display("timeout waiting for a response in row %0d", idx);
				abort_run();
			end
			@(posedge clk);
			#1;
			cycles++;
			if (lookup_rsp.valid) begin
				if (!want_l || seen_l) begin
					$display("unexpected lookup response in row %0d", idx);
					abort_run();
				end
				got_l = lookup_rsp;
				seen_l = 1'b1;
			end
			if (fill_rsp.valid) begin
				if (!want_f || seen_f) begin
					$display("unexpected fill response in row %0d", idx);
					abort_run();
				end
				got_f = fill_rsp;
				seen_f = 1'b1;
			end
		end
		exp_l.valid = 1'b1;
		exp_l.hit = r.exp_hit;
		exp_l.way = r.exp_way;
		exp_f.valid = 1'b1;
		exp_f.way = r.exp_way;
		exp_f.was_present = r.exp_present;
		if (want_l) begin
			check_lookup(idx, got_l, exp_l);
		end
		if (want_f) begin
			check_fill(idx, got_f, exp_f);
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		reset = 1'b1;
		lookup_req = '0;
		fill_req = '0;
		build_table();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (rows[i]) begin
			run_row(i, rows[i]);
		end
		if (dut_i.props_i.error_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display("%0d protocol or grant assertions failed", dut_i.props_i.error_count);
			abort_run();
		end
	end

endmodule

`default_nettype wire

// ==== tag_dir_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_dir_properties
	import cache_geom_pkg::*;
	import dir_xact_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire lookup_req_t lookup_req,
	input wire lookup_rsp_t lookup_rsp,
	input wire fill_req_t fill_req,
	input wire fill_rsp_t fill_rsp,
	input wire logic lookup_gnt,
	input wire logic fill_gnt,
	input wire set_cmd_t ram_cmd
);

	logic lookup_busy_q; // request accepted, no response yet
	logic fill_busy_q;
	int error_count = 0; // failed assertions so far

	always_ff @(posedge clk) begin
		if (reset) begin
			lookup_busy_q <= 1'b0;
			fill_busy_q <= 1'b0;
		end else begin
			if (lookup_req.valid) lookup_busy_q <= 1'b1;
			else if (lookup_rsp.valid) lookup_busy_q <= 1'b0;
			if (fill_req.valid) fill_busy_q <= 1'b1;
			else if (fill_rsp.valid) fill_busy_q <= 1'b0;
		end
	end

	//////////////////////////////
	// arbiter grants
	//////////////////////////////

	grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({lookup_gnt, fill_gnt}))
		else begin
			error_count++;
			$error("both engines granted in one cycle");
		end

	lookup_lock_held: assert property (@(posedge clk) disable iff (reset)
		(lookup_gnt && ram_cmd.lock) |=> lookup_gnt)
		else begin
			error_count++;
			$error("lookup engine lost its locked grant");
		end

	fill_lock_held: assert property (@(posedge clk) disable iff (reset)
		(fill_gnt && ram_cmd.lock) |=> fill_gnt)
		else begin
			error_count++;
			$error("fill engine lost its locked grant");
		end

	//////////////////////////////
	// port protocol
	//////////////////////////////

	lookup_one_outstanding: assert property (@(posedge clk) disable iff (reset)
		lookup_req.valid |-> !lookup_busy_q)
		else begin
			error_count++;
			$error("lookup request while previous one is outstanding");
		end

	fill_one_outstanding: assert property (@(posedge clk) disable iff (reset)
		fill_req.valid |-> !fill_busy_q)
		else begin
			error_count++;
			$error("fill request while previous one is outstanding");
		end

endmodule

bind tag_dir_top tag_dir_properties props_i (
	.clk(clk),
	.reset(reset),
	.lookup_req(lookup_req),
	.lookup_rsp(lookup_rsp),
	.fill_req(fill_req),
	.fill_rsp(fill_rsp),
	.lookup_gnt(lookup_gnt),
	.fill_gnt(fill_gnt),
	.ram_cmd(ram_cmd)
);

`default_nettype wire

// ==== tag_dir_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_dir_top
	import cache_geom_pkg::*;
	import dir_xact_pkg::*;
#(
	parameter int num_sets = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire lookup_req_t lookup_req,
	output lookup_rsp_t lookup_rsp,
	input wire fill_req_t fill_req,
	output fill_rsp_t fill_rsp
);

	localparam int set_w = $clog2(num_sets);

	set_cmd_t lookup_cmd;
	set_cmd_t fill_cmd;
	set_cmd_t ram_cmd;
	logic lookup_gnt;
	logic fill_gnt;
	set_data_t ram_data; // read data seen by both engines

	//////////////////////////////
	// engines
	//////////////////////////////

	lookup_engine #(.num_sets(num_sets)) lookup_i (
		.clk(clk),
		.reset(reset),
		.req(lookup_req),
		.rsp(lookup_rsp),
		.cmd(lookup_cmd),
		.gnt(lookup_gnt),
		.data(ram_data)
	);

	fill_engine #(.num_sets(num_sets)) fill_i (
		.clk(clk),
		.reset(reset),
		.req(fill_req),
		.rsp(fill_rsp),
		.cmd(fill_cmd),
		.gnt(fill_gnt),
		.data(ram_data)
	);

	//////////////////////////////
	// shared set state
	//////////////////////////////

	state_arbiter arb_i (
		.clk(clk),
		.reset(reset),
		.lookup_cmd(lookup_cmd),
		.fill_cmd(fill_cmd),
		.lookup_gnt(lookup_gnt),
		.fill_gnt(fill_gnt),
		.ram_cmd(ram_cmd)
	);

	set_state_ram #(.num_sets(num_sets), .payload_t(tag_entry_t)) tag_ram_i (
		.clk(clk),
		.reset(reset),
		.addr(ram_cmd.set_idx[set_w-1:0]),
		.we(ram_cmd.wr_tags),
		.wdata(ram_cmd.tags),
		.rdata(ram_data.tags)
	);

	set_state_ram #(.num_sets(num_sets), .payload_t(plru_bits_t)) plru_ram_i (
		.clk(clk),
		.reset(reset),
		.addr(ram_cmd.set_idx[set_w-1:0]),
		.we(ram_cmd.wr_plru),
		.wdata(ram_cmd.plru),
		.rdata(ram_data.plru)
	);

endmodule

`default_nettype wire

// ==== fill_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module fill_engine
	import cache_geom_pkg::*;
	import dir_xact_pkg::*;
#(
	parameter int num_sets = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire fill_req_t req,
	output fill_rsp_t rsp,
	output set_cmd_t cmd,
	input wire logic gnt,
	input wire set_data_t data
);

	localparam int set_w = $clog2(num_sets);

	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_decide,
		st_write,
		st_respond
	} state_t;

	state_t state_q;
	line_addr_t addr_q;
	logic present_q;
	way_idx_t way_q;
	tag_entry_t tags_q;
	plru_bits_t plru_q;
	logic hit_found;
	logic free_found;
	way_idx_t hit_way;
	way_idx_t free_way;
	way_idx_t way_sel;
	way_idx_t victim;
	plru_bits_t touched;
	tag_entry_t new_tags;

	plru_tree plru_i (
		.bits(data.plru),
		.touch_way(way_sel),
		.victim(victim),
		.touched_bits(touched)
	);

	always_comb begin
		hit_found = 1'b0;
		free_found = 1'b0;
		hit_way = '0;
		free_way = '0;
		for (int w = num_ways - 1; w >= 0; w--) begin // lowest index wins
			if (data.tags.valid[w] && data.tags.tag[w] == addr_q) begin
				hit_found = 1'b1;
				hit_way = way_idx_t'(w);
			end
			if (!data.tags.valid[w]) begin
				free_found = 1'b1;
				free_way = way_idx_t'(w);
			end
		end

		if (hit_found) way_sel = hit_way;
		else if (free_found) way_sel = free_way;
		else way_sel = victim;

		new_tags = data.tags;
		new_tags.valid[way_sel] = 1'b1;
		new_tags.tag[way_sel] = addr_q; // same value when present
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: if (req.valid) state_q <= st_read;
				st_read: if (gnt) state_q <= st_decide;
				st_decide: state_q <= st_write;
				st_write: if (gnt) state_q <= st_respond;
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && req.valid) begin
			addr_q <= req.addr;
		end
		if (state_q == st_decide) begin
			present_q <= hit_found;
			way_q <= way_sel;
			tags_q <= new_tags;
			plru_q <= touched;
		end
	end

	always_comb begin
		cmd = '0;
		cmd.set_idx = 8'(addr_q[set_w-1:0]);
		cmd.tags = tags_q;
		cmd.plru = plru_q;
		case (state_q)
			st_read, st_decide: begin
				cmd.req = 1'b1;
				cmd.lock = 1'b1;
			end
			st_write: begin
				cmd.req = 1'b1; // releases the lock
				cmd.wr_tags = 1'b1;
				cmd.wr_plru = 1'b1;
			end
			default: cmd.req = 1'b0;
		endcase
	end

	assign rsp.valid = (state_q == st_respond);
	assign rsp.way = way_q;
	assign rsp.was_present = present_q;

endmodule

`default_nettype wire

// ==== lookup_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module lookup_engine
	import cache_geom_pkg::*;
	import dir_xact_pkg::*;
#(
	parameter int num_sets = 16
) (
	input wire logic clk,
	input wire logic reset,
	input wire lookup_req_t req,
	output lookup_rsp_t rsp,
	output set_cmd_t cmd,
	input wire logic gnt,
	input wire set_data_t data
);

	localparam int set_w = $clog2(num_sets);

	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_decide,
		st_write,
		st_respond
	} state_t;

	state_t state_q;
	line_addr_t addr_q;
	logic hit_q;
	way_idx_t way_q;
	plru_bits_t plru_q;
	logic hit_found;
	way_idx_t hit_way;
	plru_bits_t touched;

	plru_tree plru_i (
		.bits(data.plru),
		.touch_way(hit_way),
		.victim(),
		.touched_bits(touched)
	);

	always_comb begin
		hit_found = 1'b0;
		hit_way = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (data.tags.valid[w] && data.tags.tag[w] == addr_q) begin
				hit_found = 1'b1;
				hit_way = way_idx_t'(w);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: if (req.valid) state_q <= st_read;
				st_read: if (gnt) state_q <= st_decide;
				st_decide: state_q <= hit_found ? st_write : st_respond;
				st_write: if (gnt) state_q <= st_respond;
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle && req.valid) begin
			addr_q <= req.addr;
		end
		if (state_q == st_decide) begin
			hit_q <= hit_found;
			way_q <= hit_way;
			plru_q <= touched;
		end
	end

	always_comb begin
		cmd = '0;
		cmd.set_idx = 8'(addr_q[set_w-1:0]);
		cmd.plru = plru_q;
		case (state_q)
			st_read: begin
				cmd.req = 1'b1;
				cmd.lock = 1'b1;
			end
			st_decide: begin
				cmd.req = 1'b1;
				cmd.lock = hit_found; // miss drops the lock, no write
			end
			st_write: begin
				cmd.req = 1'b1;
				cmd.wr_plru = 1'b1;
			end
			default: cmd.req = 1'b0;
		endcase
	end

	assign rsp.valid = (state_q == st_respond);
	assign rsp.hit = hit_q;
	assign rsp.way = way_q;

endmodule

`default_nettype wire

// ==== plru_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module plru_tree
	import cache_geom_pkg::*;
(
	input wire plru_bits_t bits,
	input wire way_idx_t touch_way,
	output way_idx_t victim,
	output plru_bits_t touched_bits
);

	//////////////////////////////
	// victim walk
	//////////////////////////////

	always_comb begin
		int node;
		node = 0;
		victim = '0;
		for (int lvl = 0; lvl < way_idx_w; lvl++) begin
			victim[way_idx_w-1-lvl] = bits[node]; // 1 = upper half is older
			node = 2 * node + 1 + int'(bits[node]);
		end
	end

	//////////////////////////////
	// touch update
	//////////////////////////////

	always_comb begin
		int node;
		logic dir;
		node = 0;
		touched_bits = bits;
		for (int lvl = 0; lvl < way_idx_w; lvl++) begin
			dir = touch_way[way_idx_w-1-lvl];
			touched_bits[node] = !dir; // point away from touched way
			node = 2 * node + 1 + int'(dir);
		end
	end

endmodule

`default_nettype wire

// ==== state_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module state_arbiter
	import cache_geom_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire set_cmd_t lookup_cmd,
	input wire set_cmd_t fill_cmd,
	output logic lookup_gnt,
	output logic fill_gnt,
	output set_cmd_t ram_cmd
);

	logic lock_q; // a read-modify-write is in flight
	logic last_fill_q; // last winner, also the lock owner

	always_comb begin
		lookup_gnt = 1'b0;
		fill_gnt = 1'b0;
		if (lock_q) begin
			lookup_gnt = !last_fill_q; // owner keeps it, req or not
			fill_gnt = last_fill_q;
		end else if (lookup_cmd.req && fill_cmd.req) begin
			lookup_gnt = last_fill_q;
			fill_gnt = !last_fill_q;
		end else begin
			lookup_gnt = lookup_cmd.req;
			fill_gnt = fill_cmd.req;
		end

		ram_cmd = '0; // loser gets no write
		if (lookup_gnt) begin
			ram_cmd = lookup_cmd;
		end else if (fill_gnt) begin
			ram_cmd = fill_cmd;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lock_q <= 1'b0;
			last_fill_q <= 1'b0;
		end else if (ram_cmd.req) begin
			lock_q <= ram_cmd.lock; // req without lock ends the hold
			last_fill_q <= fill_gnt;
		end
	end

endmodule

`default_nettype wire

// ==== set_state_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module set_state_ram #(
	parameter int num_sets = 16,
	parameter type payload_t = logic
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [$clog2(num_sets)-1:0] addr,
	input wire logic we,
	input wire payload_t wdata,
	output payload_t rdata
);

	payload_t mem [num_sets];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_sets; i++) begin
				mem[i] <= '0; // all ways invalid, tree at way 0
			end
			rdata <= '0;
		end else begin
			if (we) begin
				mem[addr] <= wdata;
			end
			rdata <= mem[addr]; // old data on a same-cycle write
		end
	end

endmodule

`default_nettype wire

// ==== dir_xact_pkg.sv ====
`default_nettype none

package dir_xact_pkg;

	import cache_geom_pkg::*;

	typedef struct packed {
		logic valid; // one-cycle strobe
		line_addr_t addr;
	} lookup_req_t;

	typedef struct packed {
		logic valid;
		logic hit;
		way_idx_t way;
	} lookup_rsp_t;

	typedef struct packed {
		logic valid;
		line_addr_t addr;
	} fill_req_t;

	typedef struct packed {
		logic valid;
		way_idx_t way;
		logic was_present; // line was already installed
	} fill_rsp_t;

endpackage

`default_nettype wire

// ==== cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

	//////////////////////////////
	// geometry
	//////////////////////////////

	localparam int num_ways = 8;
	localparam int way_idx_w = 3;
	localparam int addr_w = 16;

	typedef logic [addr_w-1:0] line_addr_t; // low bits index the set
	typedef logic [way_idx_w-1:0] way_idx_t;

	typedef struct packed {
		logic [num_ways-1:0] valid;
		line_addr_t [num_ways-1:0] tag; // full line address per way
	} tag_entry_t;

	typedef logic [num_ways-2:0] plru_bits_t; // node 0 is the root

	//////////////////////////////
	// set access
	//////////////////////////////

	typedef struct packed {
		logic req;
		logic lock; // hold grant for the write
		logic [7:0] set_idx;
		logic wr_tags;
		logic wr_plru;
		tag_entry_t tags;
		plru_bits_t plru;
	} set_cmd_t;

	typedef struct packed {
		tag_entry_t tags;
		plru_bits_t plru;
	} set_data_t;

endpackage

`default_nettype wire
